// ==== hw/rdma_xmit_defines.svh ====
// Fixed widths, FIFO depths and header constants. The data FIFO must hold the longest burst
`ifndef RDMA_XMIT_DEFINES_SVH
`define RDMA_XMIT_DEFINES_SVH

// ============================================================
// Bus widths
// ============================================================

// Stream and W channel width in bytes
`define RDMA_STREAM_WBYTS 64
// Target address width in bytes
`define RDMA_ADDR_WBYTS 8

// ============================================================
// Buffering
// ============================================================

// Payload FIFO depth in beats
`define RDMA_DATA_FIFO_DEPTH 256
// Length and address FIFO depth in packets
`define RDMA_PKT_FIFO_DEPTH 16
// Width of the outstanding write response counter
`define RDMA_CNT_W 16

// ============================================================
// Fixed header fields
// ============================================================

`define RDMA_SRC_MAC_LO 8'h02
// 10.1.1.2
`define RDMA_SRC_IP 32'h0A01_0102
// 10.1.1.255
`define RDMA_DST_IP 32'h0A01_01FF
`define RDMA_UDP_SRC_PORT 16'd1000
// Must match the port of the receiving packet filter
`define RDMA_UDP_DST_PORT 16'd32002
`define RDMA_MAGIC 16'h0122

// Header lengths in bytes
`define IP_HDR_LEN 20
`define UDP_HDR_LEN 8
`define RDMA_HDR_LEN 22

`endif

// ==== hw/rdma_xmit_pkg.sv ====
// Shared types of the RDMA transmit path; widths come from the defines header
`include "rdma_xmit_defines.svh"

package rdma_xmit_pkg;

   // ============================================================
   // Plain vectors
   // ============================================================

   // One full stream beat of payload
   typedef logic [`RDMA_STREAM_WBYTS*8-1:0] stream_data_t;

   // Byte enables for one beat
   // On the W side this carries WSTRB, on the stream side TKEEP
   typedef logic [`RDMA_STREAM_WBYTS-1:0] stream_keep_t;

   // Packet length in bytes
   typedef logic [15:0] byte_len_t;

   // Remote target address carried in the RDMA header
   typedef logic [`RDMA_ADDR_WBYTS*8-1:0] rdma_addr_t;

   // ============================================================
   // Stream beat
   // ============================================================

   // Data, byte mask and end of packet marker
   typedef struct packed {
      stream_data_t data;
      stream_keep_t keep;
      logic         last;
   } stream_beat_t;

   // ============================================================
   // Framer FSM
   // ============================================================

   // Header beat first, then payload beats until last
   typedef enum logic {
      ST_HEADER,
      ST_DATA
   } tx_state_e;

endpackage

// ==== hw/stream_fifo.sv ====
// Single clock show-ahead FIFO; out_data is only meaningful while out_valid is high
`timescale 1ns/10ps

module stream_fifo #(
   parameter int WIDTH = 8,
   parameter int DEPTH = 16
) (
   input  logic             clk,
   input  logic             resetn,
   input  logic [WIDTH-1:0] in_data,
   input  logic             in_valid,
   output logic             in_ready,
   output logic [WIDTH-1:0] out_data,
   output logic             out_valid,
   input  logic             out_ready
);

   // Pointer and occupancy widths
   localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PW-1:0]    wr_ptr;
   logic [PW-1:0]    rd_ptr;
   logic [CW-1:0]    count;
   logic             push;
   logic             pop;

   // Full and empty straight from the count
   assign in_ready  = (count != CW'(DEPTH));
   assign out_valid = (count != '0);
   assign push      = in_valid & in_ready;
   assign pop       = out_valid & out_ready;

   // Head word shown without waiting for a read
   assign out_data = mem[rd_ptr];

   // Storage array
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_data;
      end
   end

   // Pointers wrap at DEPTH, which need not be a power of two
   always_ff @(posedge clk) begin
      if (!resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // Simultaneous push and pop leave the count alone
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== hw/wr_length_counter.sv ====
// Assumes byte-packed writes; a burst longer than the data FIFO stalls the W channel for good
`timescale 1ns/10ps
`include "rdma_xmit_defines.svh"

module wr_length_counter (
   input  logic                       clk,
   input  logic                       resetn,
   input  rdma_xmit_pkg::stream_beat_t w_beat,
   input  logic                       w_valid,
   output logic                       w_ready,
   input  logic                       data_ready,
   output logic                       data_push,
   output rdma_xmit_pkg::byte_len_t   len_data,
   output logic                       len_valid,
   input  logic                       len_ready,
   output logic                       burst_done
);

   // Bytes in one beat, 0 to 64
   logic [$clog2(`RDMA_STREAM_WBYTS):0] beat_bytes;
   // Bytes of the burst so far, not counting the current beat
   rdma_xmit_pkg::byte_len_t            acc;

   // Count set strobe bits
   always_comb begin
      beat_bytes = '0;
      for (int i = 0; i < `RDMA_STREAM_WBYTS; i++) begin
         beat_bytes = beat_bytes + w_beat.keep[i];
      end
   end

   // Accept a beat only when both FIFOs have room, so payload and length stay paired
   assign w_ready   = data_ready & len_ready;
   assign data_push = w_valid & w_ready;

   // Running total including this beat, pushed on the last one
   assign len_data   = acc + rdma_xmit_pkg::byte_len_t'(beat_bytes);
   assign len_valid  = data_push & w_beat.last;
   assign burst_done = len_valid;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         acc <= '0;
      end else if (data_push) begin
         // Restart for the next burst after last
         acc <= w_beat.last ? '0 : len_data;
      end
   end

endmodule

// ==== hw/bresp_tracker.sv ====
// Always answers OKAY; counter wraps beyond 2**RDMA_CNT_W-1 unanswered bursts
`timescale 1ns/10ps
`include "rdma_xmit_defines.svh"

module bresp_tracker (
   input  logic       clk,
   input  logic       resetn,
   input  logic       burst_done,
   input  logic       bready,
   output logic       bvalid,
   output logic [1:0] bresp
);

   // Bursts completed but not yet answered
   logic [`RDMA_CNT_W-1:0] owed;
   logic                   b_fire;

   assign bvalid = (owed != '0);
   assign b_fire = bvalid & bready;

   // OKAY
   assign bresp = 2'b00;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         owed <= '0;
      end else begin
         // New burst and a response in the same cycle cancel out
         case ({burst_done, b_fire})
            2'b10:   owed <= owed + 1'b1;
            2'b01:   owed <= owed - 1'b1;
            default: owed <= owed;
         endcase
      end
   end

endmodule

// ==== hw/rdma_header_builder.sv ====
// Pure combinational header; UDP checksum is sent as zero, output is little-endian by byte
`timescale 1ns/10ps
`include "rdma_xmit_defines.svh"

module rdma_header_builder (
   input  rdma_xmit_pkg::byte_len_t    pkt_len,
   input  rdma_xmit_pkg::rdma_addr_t   target_addr,
   output rdma_xmit_pkg::stream_data_t header
);

   // ============================================================
   // Fixed fields
   // ============================================================

   localparam logic [47:0] ETH_DST_MAC = 48'hFFFF_FFFF_FFFF;
   localparam logic [47:0] ETH_SRC_MAC = {40'hC4_00AD_0000, `RDMA_SRC_MAC_LO};
   localparam logic [15:0] ETH_TYPE    = 16'h0800;
   localparam logic [15:0] IP_VER_DSF  = 16'h4500;
   localparam logic [15:0] IP_ID       = 16'hDEAD;
   localparam logic [15:0] IP_FLAGS    = 16'h4000;
   localparam logic [15:0] IP_TTL_PROT = 16'h4011;
   localparam logic [31:0] SRC_IP      = `RDMA_SRC_IP;
   localparam logic [31:0] DST_IP      = `RDMA_DST_IP;

   rdma_xmit_pkg::byte_len_t    ip_len;
   rdma_xmit_pkg::byte_len_t    udp_len;
   logic [31:0]                 cs32;
   logic [15:0]                 ip_csum;
   rdma_xmit_pkg::stream_data_t hdr_be;

   // IP length covers IP, UDP and RDMA headers plus payload
   assign ip_len  = 16'(`IP_HDR_LEN + `UDP_HDR_LEN + `RDMA_HDR_LEN) + pkt_len;
   assign udp_len = 16'(`UDP_HDR_LEN + `RDMA_HDR_LEN) + pkt_len;

   // One's complement sum of the IP header with the checksum field as zero
   assign cs32 = IP_VER_DSF + IP_ID + IP_FLAGS + IP_TTL_PROT
               + SRC_IP[31:16] + SRC_IP[15:0]
               + DST_IP[31:16] + DST_IP[15:0]
               + ip_len;
   // Single fold is enough for nine words
   assign ip_csum = ~(cs32[15:0] + cs32[31:16]);

   // ============================================================
   // Header in wire order, first byte in the top bits
   // ============================================================

   assign hdr_be = {
      // Ethernet, 14 bytes
      ETH_DST_MAC, ETH_SRC_MAC, ETH_TYPE,
      // IPv4, 20 bytes
      IP_VER_DSF, ip_len, IP_ID, IP_FLAGS, IP_TTL_PROT, ip_csum,
      SRC_IP, DST_IP,
      // UDP, 8 bytes
      `RDMA_UDP_SRC_PORT, `RDMA_UDP_DST_PORT, udp_len, 16'h0000,
      // RDMA, 22 bytes with 12 reserved
      `RDMA_MAGIC, target_addr, 96'h0
   };

   // MAC sends byte 0 from bits 7 to 0, so flip the byte order
   always_comb begin
      for (int i = 0; i < `RDMA_STREAM_WBYTS; i++) begin
         header[i*8 +: 8] = hdr_be[(`RDMA_STREAM_WBYTS-1-i)*8 +: 8];
      end
   end

endmodule

// ==== hw/tx_framer.sv ====
// Expects the whole payload buffered before its length appears; one address used per packet
`timescale 1ns/10ps

module tx_framer (
   input  logic                        clk,
   input  logic                        resetn,
   // Length FIFO output
   input  rdma_xmit_pkg::byte_len_t    len_data,
   input  logic                        len_valid,
   output logic                        len_ready,
   // Address FIFO output
   input  rdma_xmit_pkg::rdma_addr_t   addr_data,
   input  logic                        addr_valid,
   output logic                        addr_ready,
   // Data FIFO output
   input  rdma_xmit_pkg::stream_beat_t pay_beat,
   input  logic                        pay_valid,
   output logic                        pay_ready,
   // Header builder
   output rdma_xmit_pkg::byte_len_t    hdr_len,
   output rdma_xmit_pkg::rdma_addr_t   hdr_addr,
   input  rdma_xmit_pkg::stream_data_t header,
   // Outgoing stream
   output rdma_xmit_pkg::stream_beat_t tx_beat,
   output logic                        tx_valid,
   input  logic                        tx_ready
);

   rdma_xmit_pkg::tx_state_e  state;
   rdma_xmit_pkg::rdma_addr_t addr_q;
   logic                      addr_held;
   logic                      addr_avail;
   logic                      in_header;
   logic                      hdr_fire;
   logic                      last_fire;

   assign in_header = (state == rdma_xmit_pkg::ST_HEADER);

   // ============================================================
   // Address capture
   // ============================================================

   // Either already held or waiting at the FIFO head
   assign addr_avail = addr_held | addr_valid;
   // Take one address whenever none is held, also during payload
   assign addr_ready = ~addr_held;
   assign hdr_addr   = addr_held ? addr_q : addr_data;
   assign hdr_len    = len_data;

   // ============================================================
   // Handshakes
   // ============================================================

   // Length pops together with the header beat
   assign len_ready = in_header & addr_avail & tx_ready;
   assign hdr_fire  = len_ready & len_valid;
   assign pay_ready = ~in_header & tx_ready;
   assign last_fire = pay_ready & pay_valid & pay_beat.last;

   // Header beat is a full 64 bytes and never the end of a packet
   always_comb begin
      if (in_header) begin
         tx_beat.data = header;
         tx_beat.keep = '1;
         tx_beat.last = 1'b0;
         tx_valid     = len_valid & addr_avail;
      end else begin
         tx_beat  = pay_beat;
         tx_valid = pay_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (addr_valid & addr_ready) begin
         addr_q <= addr_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         state     <= rdma_xmit_pkg::ST_HEADER;
         addr_held <= 1'b0;
      end else begin
         // Address popped and used on the same edge is never held
         if (hdr_fire) begin
            addr_held <= 1'b0;
         end else if (addr_valid & addr_ready) begin
            addr_held <= 1'b1;
         end
         if (hdr_fire) begin
            state <= rdma_xmit_pkg::ST_DATA;
         end else if (last_fire) begin
            state <= rdma_xmit_pkg::ST_HEADER;
         end
      end
   end

endmodule

// ==== hw/rdma_xmit_top.sv ====
// AXI4 write-only slave; AW attributes beyond the address are not used and reads are absent
`timescale 1ns/10ps
`include "rdma_xmit_defines.svh"

module rdma_xmit_top (
   input  logic                        clk,
   input  logic                        resetn,
   // AW channel
   input  rdma_xmit_pkg::rdma_addr_t   s_axi_awaddr,
   input  logic                        s_axi_awvalid,
   output logic                        s_axi_awready,
   // W channel
   input  rdma_xmit_pkg::stream_data_t s_axi_wdata,
   input  rdma_xmit_pkg::stream_keep_t s_axi_wstrb,
   input  logic                        s_axi_wlast,
   input  logic                        s_axi_wvalid,
   output logic                        s_axi_wready,
   // B channel
   output logic [1:0]                  s_axi_bresp,
   output logic                        s_axi_bvalid,
   input  logic                        s_axi_bready,
   // Outgoing stream
   output rdma_xmit_pkg::stream_beat_t tx_beat,
   output logic                        tx_valid,
   input  logic                        tx_ready
);

   // ============================================================
   // Internal channels
   // ============================================================

   rdma_xmit_pkg::stream_beat_t w_beat;
   logic                        data_push;
   logic                        data_ready;
   rdma_xmit_pkg::stream_beat_t pay_beat;
   logic                        pay_valid;
   logic                        pay_ready;
   rdma_xmit_pkg::byte_len_t    len_in;
   logic                        len_in_valid;
   logic                        len_in_ready;
   rdma_xmit_pkg::byte_len_t    len_out;
   logic                        len_out_valid;
   logic                        len_out_ready;
   rdma_xmit_pkg::rdma_addr_t   addr_out;
   logic                        addr_out_valid;
   logic                        addr_out_ready;
   logic                        burst_done;
   rdma_xmit_pkg::byte_len_t    hdr_len;
   rdma_xmit_pkg::rdma_addr_t   hdr_addr;
   rdma_xmit_pkg::stream_data_t header;

   // W beat with the strobe in the keep slot
   assign w_beat = {s_axi_wdata, s_axi_wstrb, s_axi_wlast};

   wr_length_counter wr_length_counter_inst (
      .clk        (clk),          .resetn    (resetn),
      .w_beat     (w_beat),       .w_valid   (s_axi_wvalid),
      .w_ready    (s_axi_wready), .data_ready(data_ready),
      .data_push  (data_push),    .len_data  (len_in),
      .len_valid  (len_in_valid), .len_ready (len_in_ready),
      .burst_done (burst_done)
   );

   // Payload beats of whole packets
   stream_fifo #(.WIDTH($bits(rdma_xmit_pkg::stream_beat_t)), .DEPTH(`RDMA_DATA_FIFO_DEPTH))
   data_fifo_inst (
      .clk      (clk),       .resetn   (resetn),
      .in_data  (w_beat),    .in_valid (data_push), .in_ready (data_ready),
      .out_data (pay_beat),  .out_valid(pay_valid), .out_ready(pay_ready)
   );

   // One length per completed burst
   stream_fifo #(.WIDTH($bits(rdma_xmit_pkg::byte_len_t)), .DEPTH(`RDMA_PKT_FIFO_DEPTH))
   len_fifo_inst (
      .clk      (clk),     .resetn   (resetn),
      .in_data  (len_in),  .in_valid (len_in_valid),  .in_ready (len_in_ready),
      .out_data (len_out), .out_valid(len_out_valid), .out_ready(len_out_ready)
   );

   // AW addresses, straight from the bus
   stream_fifo #(.WIDTH($bits(rdma_xmit_pkg::rdma_addr_t)), .DEPTH(`RDMA_PKT_FIFO_DEPTH))
   addr_fifo_inst (
      .clk      (clk),          .resetn   (resetn),
      .in_data  (s_axi_awaddr), .in_valid (s_axi_awvalid),  .in_ready (s_axi_awready),
      .out_data (addr_out),     .out_valid(addr_out_valid), .out_ready(addr_out_ready)
   );

   bresp_tracker bresp_tracker_inst (
      .clk   (clk),          .resetn(resetn),
      .burst_done(burst_done), .bready(s_axi_bready),
      .bvalid(s_axi_bvalid), .bresp (s_axi_bresp)
   );

   rdma_header_builder rdma_header_builder_inst (
      .pkt_len(hdr_len), .target_addr(hdr_addr), .header(header)
   );

   tx_framer tx_framer_inst (
      .clk       (clk),           .resetn    (resetn),
      .len_data  (len_out),       .len_valid (len_out_valid),  .len_ready (len_out_ready),
      .addr_data (addr_out),      .addr_valid(addr_out_valid), .addr_ready(addr_out_ready),
      .pay_beat  (pay_beat),      .pay_valid (pay_valid),      .pay_ready (pay_ready),
      .hdr_len   (hdr_len),       .hdr_addr  (hdr_addr),       .header    (header),
      .tx_beat   (tx_beat),       .tx_valid  (tx_valid),       .tx_ready  (tx_ready)
   );

endmodule

// ==== verif/rdma_xmit_assert.sv ====
// Protocol checks on the top level ports; holds only with a clean reset on resetn
`timescale 1ns/10ps

module rdma_xmit_assert (
   input logic                        clk,
   input logic                        resetn,
   input rdma_xmit_pkg::stream_beat_t tx_beat,
   input logic                        tx_valid,
   input logic                        tx_ready,
   input logic                        s_axi_bvalid,
   input logic                        s_axi_bready
);

   // Number of failed assertions so far
   int fail_count = 0;

   // ============================================================
   // Stream and B channel handshakes
   // ============================================================

   // Stalled beat keeps valid and content
   tx_stall_stable: assert property (
      @(posedge clk) disable iff (!resetn)
      tx_valid && !tx_ready |=> tx_valid && $stable(tx_beat)
   ) else begin
      fail_count++;
      $error("tx beat changed or dropped while stalled");
   end

   // Owed response stays offered until taken
   bvalid_hold: assert property (
      @(posedge clk) disable iff (!resetn)
      s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid
   ) else begin
      fail_count++;
      $error("s_axi_bvalid dropped before s_axi_bready");
   end

   // One edge into reset both outputs are idle
   reset_idle: assert property (
      @(posedge clk)
      !resetn |=> !s_axi_bvalid && !tx_valid
   ) else begin
      fail_count++;
      $error("bvalid or tx_valid high during reset");
   end

endmodule

bind rdma_xmit_top rdma_xmit_assert rdma_xmit_assert_inst (
   .clk          (clk),
   .resetn       (resetn),
   .tx_beat      (tx_beat),
   .tx_valid     (tx_valid),
   .tx_ready     (tx_ready),
   .s_axi_bvalid (s_axi_bvalid),
   .s_axi_bready (s_axi_bready)
);

// ==== verif/rdma_xmit_tb.sv ====
// Self-checking testbench; assumes W bursts follow AW order, sends a fixed number of random packets
`timescale 1ns/10ps
`include "rdma_xmit_defines.svh"

module rdma_xmit_tb;

   localparam int NPKT = 40;
   // Beats per packet at most
   localparam int MAXB = 4;
   // Cycles allowed for one handshake
   localparam int TMO = 2000;
   // Cycles allowed for the whole traffic to drain
   localparam int DONE_TMO = 20000;

   logic                        clk;
   logic                        resetn;
   rdma_xmit_pkg::rdma_addr_t   s_axi_awaddr;
   logic                        s_axi_awvalid;
   logic                        s_axi_awready;
   rdma_xmit_pkg::stream_data_t s_axi_wdata;
   rdma_xmit_pkg::stream_keep_t s_axi_wstrb;
   logic                        s_axi_wlast;
   logic                        s_axi_wvalid;
   logic                        s_axi_wready;
   logic [1:0]                  s_axi_bresp;
   logic                        s_axi_bvalid;
   logic                        s_axi_bready;
   rdma_xmit_pkg::stream_beat_t tx_beat;
   logic                        tx_valid;
   logic                        tx_ready;

   // Stimulus seeds
   integer seed = 32'h201d_769c;
   integer rdy_seed;
   integer b_seed;

   // Generated packets
   int                          pkt_nb [NPKT];
   rdma_xmit_pkg::rdma_addr_t   pkt_addr [NPKT];
   int                          aw_gap [NPKT];
   int                          w_gap [NPKT];
   rdma_xmit_pkg::stream_beat_t beat_mem [NPKT*MAXB];

   // Reference model queues in packet order
   rdma_xmit_pkg::byte_len_t    exp_len_q [$];
   rdma_xmit_pkg::rdma_addr_t   exp_addr_q [$];
   rdma_xmit_pkg::stream_beat_t exp_beat_q [$];

   // Checker state and counts
   logic                        in_pkt = 1'b0;
   logic                        hung = 1'b0;
   rdma_xmit_pkg::byte_len_t    cur_len;
   int                          cur_beats;
   int                          pkt_err0;
   int                          errors = 0;
   int                          checks = 0;
   int                          pkts_rx = 0;
   int                          bursts_done = 0;
   int                          b_count = 0;

   rdma_xmit_top rdma_xmit_top_inst (
      .clk          (clk),          .resetn       (resetn),
      .s_axi_awaddr (s_axi_awaddr), .s_axi_awvalid(s_axi_awvalid), .s_axi_awready(s_axi_awready),
      .s_axi_wdata  (s_axi_wdata),  .s_axi_wstrb  (s_axi_wstrb),   .s_axi_wlast  (s_axi_wlast),
      .s_axi_wvalid (s_axi_wvalid), .s_axi_wready (s_axi_wready),
      .s_axi_bresp  (s_axi_bresp),  .s_axi_bvalid (s_axi_bvalid),  .s_axi_bready (s_axi_bready),
      .tx_beat      (tx_beat),      .tx_valid     (tx_valid),      .tx_ready     (tx_ready)
   );

   always #5 clk = ~clk;

   // ============================================================
   // Reference model
   // ============================================================

   // Write n bytes of val at byte offset off with the most significant byte first
   function automatic rdma_xmit_pkg::stream_data_t put_be(input rdma_xmit_pkg::stream_data_t d,
                                                          input int off, input logic [63:0] val,
                                                          input int n);
      rdma_xmit_pkg::stream_data_t r;
      r = d;
      for (int k = 0; k < n; k++) begin
         r[(off + k)*8 +: 8] = val[(n - 1 - k)*8 +: 8];
      end
      return r;
   endfunction

   // Wire byte k of the header lands in bits 8k+7 to 8k
   function automatic rdma_xmit_pkg::stream_data_t expected_header(
      input rdma_xmit_pkg::byte_len_t len, input rdma_xmit_pkg::rdma_addr_t addr);
      rdma_xmit_pkg::stream_data_t h;
      logic [15:0]                 ip_len;
      logic [15:0]                 udp_len;
      logic [31:0]                 sum;
      logic [15:0]                 csum;
      ip_len  = len + 16'(`IP_HDR_LEN + `UDP_HDR_LEN + `RDMA_HDR_LEN);
      udp_len = len + 16'(`UDP_HDR_LEN + `RDMA_HDR_LEN);
      // Sum of nine IP words followed by one fold and inversion
      sum = 32'h4500 + 32'hDEAD + 32'h4000 + 32'h4011 + ip_len
          + (`RDMA_SRC_IP >> 16) + (`RDMA_SRC_IP & 32'hFFFF)
          + (`RDMA_DST_IP >> 16) + (`RDMA_DST_IP & 32'hFFFF);
      csum = ~(sum[15:0] + sum[31:16]);
      h = '0;
      // Ethernet
      h = put_be(h, 0, 64'hFFFF_FFFF_FFFF, 6);
      h = put_be(h, 6, {40'hC4_00AD_0000, `RDMA_SRC_MAC_LO}, 6);
      h = put_be(h, 12, 16'h0800, 2);
      // IPv4
      h = put_be(h, 14, 16'h4500, 2);
      h = put_be(h, 16, ip_len, 2);
      h = put_be(h, 18, 16'hDEAD, 2);
      h = put_be(h, 20, 16'h4000, 2);
      h = put_be(h, 22, 16'h4011, 2);
      h = put_be(h, 24, csum, 2);
      h = put_be(h, 26, `RDMA_SRC_IP, 4);
      h = put_be(h, 30, `RDMA_DST_IP, 4);
      // UDP with zero checksum
      h = put_be(h, 34, `RDMA_UDP_SRC_PORT, 2);
      h = put_be(h, 36, `RDMA_UDP_DST_PORT, 2);
      h = put_be(h, 38, udp_len, 2);
      // RDMA magic and target with the reserved tail left zero
      h = put_be(h, 42, `RDMA_MAGIC, 2);
      h = put_be(h, 44, addr, 8);
      return h;
   endfunction

   task automatic gen_packets();
      rdma_xmit_pkg::stream_beat_t beat;
      rdma_xmit_pkg::byte_len_t    len;
      int                          nbytes;
      for (int p = 0; p < NPKT; p++) begin
         pkt_nb[p]   = 1 + $unsigned($random(seed)) % MAXB;
         pkt_addr[p] = {$random(seed), $random(seed)};
         // Wider AW gaps let the address trail its data now and then
         aw_gap[p]   = $unsigned($random(seed)) % 12;
         w_gap[p]    = $unsigned($random(seed)) % 4;
         len = '0;
         for (int b = 0; b < pkt_nb[p]; b++) begin
            for (int w = 0; w < 16; w++) begin
               beat.data[w*32 +: 32] = $random(seed);
            end
            beat.last = (b == pkt_nb[p] - 1);
            // Only the last beat may be partial and it fills from the low byte
            nbytes    = beat.last ? 1 + $unsigned($random(seed)) % 64 : 64;
            beat.keep = {64{1'b1}} >> (64 - nbytes);
            len       = len + nbytes;
            beat_mem[p*MAXB + b] = beat;
            exp_beat_q.push_back(beat);
         end
         exp_len_q.push_back(len);
         exp_addr_q.push_back(pkt_addr[p]);
      end
   endtask

   // ============================================================
   // Checks
   // ============================================================

   task automatic compare_field(input string name, input logic [511:0] exp,
                                input logic [511:0] got);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("ERR at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
      end
   endtask

   task automatic compare_beat(input string tag, input rdma_xmit_pkg::stream_beat_t exp);
      compare_field({tag, " tx_beat.data"}, exp.data, tx_beat.data);
      compare_field({tag, " tx_beat.keep"}, exp.keep, tx_beat.keep);
      compare_field({tag, " tx_beat.last"}, exp.last, tx_beat.last);
   endtask

   task automatic check_tx_beat();
      rdma_xmit_pkg::stream_beat_t exp;
      if (!in_pkt) begin
         assert (exp_len_q.size() != 0) else begin
            errors++;
            $display("Header beat at %0t ns with no packet outstanding", $time);
         end
         if (exp_len_q.size() != 0) begin
            pkt_err0  = errors;
            cur_len   = exp_len_q.pop_front();
            cur_beats = 0;
            exp.data  = expected_header(cur_len, exp_addr_q.pop_front());
            exp.keep  = '1;
            exp.last  = 1'b0;
            compare_beat("header", exp);
            in_pkt = 1'b1;
         end
      end else begin
         assert (exp_beat_q.size() != 0) else begin
            errors++;
            $display("Payload beat at %0t ns beyond the written data", $time);
         end
         if (exp_beat_q.size() != 0) begin
            exp = exp_beat_q.pop_front();
            compare_beat("payload", exp);
            cur_beats++;
            // Packet ends where the written burst ended
            if (exp.last) begin
               in_pkt = 1'b0;
               $display("packet %0d: %0d bytes in %0d beats, %s", pkts_rx, cur_len, cur_beats,
                        (errors == pkt_err0) ? "ok" : "mismatch");
               pkts_rx++;
            end
         end
      end
   endtask

   // B is checked before W so that a last beat on the same edge cannot excuse a response
   always @(posedge clk) begin
      if (resetn) begin
         if (s_axi_bvalid && s_axi_bready) begin
            compare_field("s_axi_bresp", 2'b00, s_axi_bresp);
            assert (b_count < bursts_done) else begin
               errors++;
               $display("Write response at %0t ns without a completed burst", $time);
            end
            b_count++;
         end
         if (s_axi_wvalid && s_axi_wready && s_axi_wlast) begin
            bursts_done++;
         end
         if (tx_valid && tx_ready) begin
            check_tx_beat();
         end
      end
   end

   // ============================================================
   // Drivers
   // ============================================================

   // Returns 1 ns after the edge that took the beat or flags a stuck channel
   task automatic wait_accept(input int ch, input string what, output logic ok);
      int   n;
      logic hit;
      n   = 0;
      hit = 1'b0;
      while (!hit && n <= TMO) begin
         @(posedge clk);
         n++;
         hit = (ch == 0) ? s_axi_awready : s_axi_wready;
      end
      ok = hit;
      if (hit) begin
         #1;
      end else begin
         hung = 1'b1;
         $display("Timeout waiting for %s at %0t ns", what, $time);
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic drive_aw();
      logic ok;
      ok = 1'b1;
      for (int p = 0; p < NPKT && ok; p++) begin
         idle_cycles(aw_gap[p]);
         s_axi_awaddr  = pkt_addr[p];
         s_axi_awvalid = 1'b1;
         wait_accept(0, "AW ready", ok);
         s_axi_awvalid = 1'b0;
      end
   endtask

   task automatic drive_w();
      rdma_xmit_pkg::stream_beat_t beat;
      logic                        ok;
      ok = 1'b1;
      for (int p = 0; p < NPKT && ok; p++) begin
         idle_cycles(w_gap[p]);
         for (int b = 0; b < pkt_nb[p] && ok; b++) begin
            beat         = beat_mem[p*MAXB + b];
            s_axi_wdata  = beat.data;
            s_axi_wstrb  = beat.keep;
            s_axi_wlast  = beat.last;
            s_axi_wvalid = 1'b1;
            wait_accept(1, "W ready", ok);
            s_axi_wvalid = 1'b0;
         end
      end
   endtask

   // Random sink stalls on the stream and on the B channel
   always @(posedge clk) begin
      #1;
      tx_ready     = ($unsigned($random(rdy_seed)) % 4) != 0;
      s_axi_bready = ($unsigned($random(b_seed)) % 3) != 0;
   end

   initial begin
      int n;
      clk           = 1'b0;
      resetn        = 1'b0;
      s_axi_awaddr  = '0;
      s_axi_awvalid = 1'b0;
      s_axi_wdata   = '0;
      s_axi_wstrb   = '0;
      s_axi_wlast   = 1'b0;
      s_axi_wvalid  = 1'b0;
      s_axi_bready  = 1'b0;
      tx_ready      = 1'b0;
      rdy_seed      = seed ^ 32'h0000_5a5a;
      b_seed        = seed ^ 32'h0000_a5a5;
      gen_packets();
      repeat (4) @(posedge clk);
      #1;
      resetn = 1'b1;
      fork
         drive_aw();
         drive_w();
      join_none
      // Every packet out and every burst answered
      n = 0;
      while ((pkts_rx < NPKT || b_count < NPKT) && !hung && n < DONE_TMO) begin
         @(posedge clk);
         n++;
      end
      if (hung || pkts_rx < NPKT || b_count < NPKT) begin
         errors++;
         $display("Timeout waiting for all packets and write responses");
      end else begin
         // Anything extra in the idle drain shows up in the checker
         repeat (50) @(posedge clk);
         assert (exp_beat_q.size() == 0 && !in_pkt && b_count == NPKT) else begin
            errors++;
            $display("Traffic left over after the last packet");
         end
      end
      // Failures of the bound protocol assertions
      errors += rdma_xmit_top_inst.rdma_xmit_assert_inst.fail_count;
      $display("packets %0d of %0d, responses %0d, checks %0d, errors %0d",
               pkts_rx, NPKT, b_count, checks, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// ==== rdma_xmit.f ====
+incdir+hw
hw/rdma_xmit_pkg.sv
hw/stream_fifo.sv
hw/wr_length_counter.sv
hw/bresp_tracker.sv
hw/rdma_header_builder.sv
hw/tx_framer.sv
hw/rdma_xmit_top.sv
verif/rdma_xmit_assert.sv
verif/rdma_xmit_tb.sv

// ==== Bender.yml ====
package:
  name: rdma_xmit

sources:
  - include_dirs:
      - hw
    files:
      - hw/rdma_xmit_pkg.sv
      - hw/stream_fifo.sv
      - hw/wr_length_counter.sv
      - hw/bresp_tracker.sv
      - hw/rdma_header_builder.sv
      - hw/tx_framer.sv
      - hw/rdma_xmit_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/rdma_xmit_assert.sv
      - verif/rdma_xmit_tb.sv
